// ==== verilog.f ====
common/lc_map_pkg.sv
common/lc_isa_pkg.sv
hw/prog_loader.sv
hw/mem_map.sv
cpu/cpu_decode.sv
cpu/cpu_execute.sv
cpu/cpu_result.sv
hw/little_computer.sv
test/little_computer_asserts.sv
test/little_computer_tb.sv

// ==== Bender.yml ====
package:
  name: little_computer

sources:
  - common/lc_map_pkg.sv
  - common/lc_isa_pkg.sv
  - hw/prog_loader.sv
  - hw/mem_map.sv
  - cpu/cpu_decode.sv
  - cpu/cpu_execute.sv
  - cpu/cpu_result.sv
  - hw/little_computer.sv
  - target: test
    files:
      - test/little_computer_asserts.sv
      - test/little_computer_tb.sv

// ==== test/little_computer_tb.sv ====
`timescale 1ns/10ps

module little_computer_tb
    import lc_isa_pkg::*, lc_map_pkg::*;
();
    localparam int TIMEOUT = 400;

    logic                 sysclk;
    logic                 sysrst;
    logic                 load_en;
    logic [7:0]           rx_byte;
    logic                 rx_valid;
    logic [LED_WIDTH-1:0] led;
    logic [7:0]           tx_byte;
    logic                 tx_valid;
    logic                 halted;

    word_t      prog [$];
    word_t      mregs [16];
    word_t      mdmem [256];
    word_t      exp_led [$];
    logic [7:0] exp_tx [$];
    logic [7:0] got_tx [$];
    int         errors;
    int         test_start;
    int         tests;

    little_computer #(.IMEM_WORDS(256), .DMEM_WORDS(256)) UUT (.*);

    always #10 sysclk = ~sysclk;

    // transmit strobes, sampled mid-cycle
    always @(negedge sysclk) begin
        if (tx_valid === 1'b1) begin
            got_tx.push_back(tx_byte);
        end
    end

    function automatic word_t rform(opcode_t o, reg_idx_t d, reg_idx_t a, reg_idx_t b);
        return {o, d, a, b};
    endfunction

    function automatic word_t iform(opcode_t o, reg_idx_t d, logic [7:0] imm);
        return {o, d, imm};
    endfunction

    function automatic int total_failures();
        return errors + UUT.asserts_c.fail_count;
    endfunction

    task automatic check_value(string name, logic [15:0] expected, logic [15:0] actual);
        assert (actual === expected) else begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(string name);
        tests++;
        $display("test %0d, %s: %s", tests, name,
                 (total_failures() == test_start) ? "ok" : "failed");
        test_start = total_failures();
    endtask

    // ISA reference model, fills the expected LED and transmit queues
    task automatic run_model();
        instr_u ins;
        word_t  a;
        word_t  b;
        word_t  d;
        int     pc;
        mregs = '{default: '0};
        exp_led.delete();
        exp_tx.delete();
        pc = 0;
        for (int steps = 0; steps < 2000; steps++) begin
            ins = instr_u'(prog[pc]);
            a = mregs[ins.r_form.ra];
            b = mregs[ins.r_form.rb];
            d = mregs[ins.r_form.rd];
            pc++;
            case (ins.r_form.opcode)
                ADD:  mregs[ins.r_form.rd] = a + b;
                SUB:  mregs[ins.r_form.rd] = a - b;
                AND:  mregs[ins.r_form.rd] = a & b;
                OR:   mregs[ins.r_form.rd] = a | b;
                XOR:  mregs[ins.r_form.rd] = a ^ b;
                LI:   mregs[ins.i_form.rd] = {8'h00, ins.i_form.imm8};
                LUI:  mregs[ins.i_form.rd] = {ins.i_form.imm8, d[7:0]};
                LW:   mregs[ins.r_form.rd] = (a < ADDR_LED) ? mdmem[a % 256] : '0;
                SW: begin
                    if (a == ADDR_LED) exp_led.push_back(word_t'(d[LED_WIDTH-1:0]));
                    else if (a == ADDR_TX) exp_tx.push_back(d[7:0]);
                    else if (a < ADDR_LED) mdmem[a % 256] = d;
                end
                JMP:  pc = ins.i_form.imm8;
                BNZ:  if (d != '0) pc = ins.i_form.imm8;
                HALT: return;
                default: ;
            endcase
        end
    endtask

    task automatic send_byte(logic [7:0] b);
        rx_byte  = b;
        rx_valid = 1'b1;
        @(negedge sysclk);
        rx_valid = 1'b0;
        repeat ($urandom_range(3)) @(negedge sysclk);
    endtask

    task automatic send_word(word_t w);
        send_byte(w[15:8]);
        send_byte(w[7:0]);
    endtask

    // core held while loading, runs from address 0 once load_en drops
    task automatic load_program();
        load_en = 1'b1;
        repeat (2) @(negedge sysclk);
        foreach (prog[i]) begin
            send_word(prog[i]);
        end
        repeat (2) @(negedge sysclk);
        got_tx.delete();
        run_model();
        load_en = 1'b0;
    endtask

    task automatic wait_halted();
        int n;
        n = 0;
        while (halted !== 1'b1 && n < TIMEOUT) begin
            @(negedge sysclk);
            n++;
        end
        if (halted !== 1'b1) begin
            $display("timeout: halted never went high");
            errors++;
        end
    endtask

    task automatic wait_led_change(logic [LED_WIDTH-1:0] old);
        int n;
        n = 0;
        while (led === old && n < TIMEOUT) begin
            @(negedge sysclk);
            n++;
        end
        if (led === old) begin
            $display("timeout: led never changed after a store");
            errors++;
        end
    endtask

    task automatic wait_tx_count(int count);
        int n;
        n = 0;
        while (got_tx.size() < count && n < TIMEOUT) begin
            @(negedge sysclk);
            n++;
        end
        if (got_tx.size() < count) begin
            $display("timeout: only %0d of %0d tx_valid strobes came", got_tx.size(), count);
            errors++;
        end
    endtask

    task automatic check_tx();
        check_value("tx_valid count", exp_tx.size(), got_tx.size());
        foreach (exp_tx[i]) begin
            if (i < got_tx.size()) check_value("tx_byte", exp_tx[i], got_tx[i]);
        end
    endtask

    initial begin
        word_t                rnd;
        logic [LED_WIDTH-1:0] prev;
        void'($urandom(23));
        sysclk   = 1'b0;
        sysrst   = 1'b0;
        load_en  = 1'b1;
        rx_byte  = 8'h00;
        rx_valid = 1'b0;
        errors     = 0;
        test_start = 0;
        tests      = 0;
        repeat (8) @(negedge sysclk);
        sysrst = 1'b1;

        // idle outputs while the loader holds the core
        repeat (12) begin
            @(negedge sysclk);
            check_value("led", 16'h0, led);
            check_value("tx_valid", 16'h0, tx_valid);
            check_value("halted", 16'h0, halted);
        end
        finish_test("after reset");

        // r15 points at the LED register
        prog = '{iform(LI, 15, 8'h00), iform(LUI, 15, 8'hFF),
                 iform(LI, 1, 8'hC5), rform(SW, 1, 15, 0),
                 iform(LUI, 1, 8'h12), rform(SW, 1, 15, 0),
                 iform(LI, 2, 8'h53), iform(LUI, 2, 8'h03),
                 rform(ADD, 3, 1, 2), rform(SW, 3, 15, 0),
                 rform(SUB, 3, 1, 2), rform(SW, 3, 15, 0),
                 rform(AND, 3, 1, 2), rform(SW, 3, 15, 0),
                 rform(OR, 3, 1, 2), rform(SW, 3, 15, 0),
                 rform(XOR, 3, 1, 2), rform(SW, 3, 15, 0),
                 iform(HALT, 0, 8'h00)};
        load_program();
        foreach (exp_led[i]) begin
            prev = led;
            wait_led_change(prev);
            check_value("led", exp_led[i], led);
        end
        wait_halted();
        finish_test("ALU and immediates");

        // r14 points at the transmit port
        prog = '{iform(LI, 14, 8'h01), iform(LUI, 14, 8'hFF)};
        for (int k = 0; k < 4; k++) begin
            rnd = word_t'($urandom());
            prog.push_back(iform(LI, 1, rnd[7:0]));
            prog.push_back(iform(LUI, 1, rnd[15:8]));
            prog.push_back(iform(LI, 2, 8'(16 + k)));
            prog.push_back(rform(SW, 1, 2, 0));
        end
        for (int k = 0; k < 4; k++) begin
            prog.push_back(iform(LI, 2, 8'(16 + k)));
            prog.push_back(rform(LW, 3, 2, 0));
            prog.push_back(rform(SW, 3, 14, 0));
        end
        prog.push_back(iform(HALT, 0, 8'h00));
        load_program();
        wait_tx_count(exp_tx.size());
        wait_halted();
        check_tx();
        finish_test("load/store round trip");

        // countdown loop body at address 4
        prog = '{iform(LI, 14, 8'h01), iform(LUI, 14, 8'hFF),
                 iform(LI, 1, 8'h05), iform(LI, 2, 8'h01),
                 rform(SW, 1, 14, 0), rform(SUB, 1, 1, 2),
                 iform(BNZ, 1, 8'h04), iform(HALT, 0, 8'h00)};
        load_program();
        wait_tx_count(exp_tx.size());
        wait_halted();
        check_tx();
        finish_test("branching");

        // shorter program must land at address 0
        prog = '{iform(LI, 14, 8'h01), iform(LUI, 14, 8'hFF),
                 iform(LI, 1, 8'hA7), rform(SW, 1, 14, 0),
                 iform(HALT, 0, 8'h00)};
        load_program();
        wait_tx_count(exp_tx.size());
        wait_halted();
        check_tx();
        finish_test("reload");

        $display("tests %0d, check errors %0d, assertion failures %0d",
                 tests, errors, UUT.asserts_c.fail_count);
        if (total_failures() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== test/little_computer_asserts.sv ====
`timescale 1ns/10ps

module little_computer_asserts import lc_map_pkg::*; (
    input logic                 sysclk,
    input logic                 sysrst,
    input logic                 load_en,
    input logic                 tx_valid,
    input logic [LED_WIDTH-1:0] led,
    input logic                 halted
);
    int unsigned fail_count = 0;

    // transmit strobe lasts a single cycle
    tx_single: assert property (@(posedge sysclk) disable iff (!sysrst)
        tx_valid |=> !tx_valid)
    else begin
        fail_count++;
        $error("tx_valid high for two consecutive cycles");
    end

    // only a new load clears the halt flag
    halt_sticky: assert property (@(posedge sysclk) disable iff (!sysrst)
        (halted && !load_en) |=> (halted || load_en))
    else begin
        fail_count++;
        $error("halted dropped while load_en stayed low");
    end

    // core is quiet during loading
    load_no_tx: assert property (@(posedge sysclk) disable iff (!sysrst)
        load_en |-> !tx_valid)
    else begin
        fail_count++;
        $error("tx_valid strobe while load_en high");
    end

    load_led_stable: assert property (@(posedge sysclk) disable iff (!sysrst)
        load_en |-> $stable(led))
    else begin
        fail_count++;
        $error("led changed while load_en high");
    end

endmodule

bind little_computer little_computer_asserts asserts_c (
    .sysclk(sysclk), .sysrst(sysrst), .load_en(load_en),
    .tx_valid(tx_valid), .led(led), .halted(halted)
);

// ==== hw/little_computer.sv ====
`timescale 1ns/10ps

module little_computer import lc_isa_pkg::*, lc_map_pkg::*; #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                 sysclk,
    input  logic                 sysrst,
    input  logic                 load_en,
    input  logic [7:0]           rx_byte,
    input  logic                 rx_valid,
    output logic [LED_WIDTH-1:0] led,
    output logic [7:0]           tx_byte,
    output logic                 tx_valid,
    output logic                 halted
);
    logic                          imem_we;
    logic [$clog2(IMEM_WORDS)-1:0] imem_waddr;
    word_t                         imem_wdata;
    logic                          core_run;
    word_t                         pc;
    instr_u                        imem_rdata;
    word_t                         dmem_addr;
    logic                          dmem_we;
    word_t                         dmem_wdata;
    word_t                         dmem_rdata;
    reg_idx_t                      ra_idx;
    reg_idx_t                      rb_idx;
    word_t                         ra_val;
    word_t                         rb_val;
    logic                          exec_go;
    opcode_t                       op;
    reg_idx_t                      rd_idx;
    logic [7:0]                    imm8;
    word_t                         opa;
    word_t                         opb;
    logic                          result_go;
    logic                          wb_en;
    reg_idx_t                      wb_idx;
    word_t                         wb_val;
    logic                          pc_load;
    word_t                         pc_target;
    logic                          halt_req;

    prog_loader #(.IMEM_WORDS(IMEM_WORDS)) loader_c (
        .sysclk(sysclk), .sysrst(sysrst), .load_en(load_en),
        .rx_byte(rx_byte), .rx_valid(rx_valid),
        .imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
        .core_run(core_run)
    );

    mem_map #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) mem_map_c (
        .sysclk(sysclk), .sysrst(sysrst),
        .imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
        .pc(pc), .imem_rdata(imem_rdata),
        .dmem_addr(dmem_addr), .dmem_we(dmem_we), .dmem_wdata(dmem_wdata),
        .dmem_rdata(dmem_rdata),
        .led(led), .tx_byte(tx_byte), .tx_valid(tx_valid)
    );

    cpu_decode decode_c (
        .sysclk(sysclk), .sysrst(sysrst), .core_run(core_run),
        .instr(imem_rdata), .result_go(result_go), .halted(halted),
        .ra_idx(ra_idx), .rb_idx(rb_idx), .ra_val(ra_val), .rb_val(rb_val),
        .exec_go(exec_go), .op(op), .rd_idx(rd_idx), .imm8(imm8),
        .opa(opa), .opb(opb)
    );

    cpu_execute execute_c (
        .sysclk(sysclk), .sysrst(sysrst), .exec_go(exec_go),
        .op(op), .rd_idx(rd_idx), .imm8(imm8), .opa(opa), .opb(opb),
        .dmem_addr(dmem_addr), .dmem_we(dmem_we), .dmem_wdata(dmem_wdata),
        .dmem_rdata(dmem_rdata),
        .result_go(result_go), .wb_en(wb_en), .wb_idx(wb_idx), .wb_val(wb_val),
        .pc_load(pc_load), .pc_target(pc_target), .halt_req(halt_req)
    );

    cpu_result result_c (
        .sysclk(sysclk), .sysrst(sysrst), .core_run(core_run),
        .result_go(result_go), .wb_en(wb_en), .wb_idx(wb_idx), .wb_val(wb_val),
        .pc_load(pc_load), .pc_target(pc_target), .halt_req(halt_req),
        .ra_idx(ra_idx), .rb_idx(rb_idx), .ra_val(ra_val), .rb_val(rb_val),
        .pc(pc), .halted(halted)
    );

endmodule

// ==== cpu/cpu_result.sv ====
`timescale 1ns/10ps

module cpu_result import lc_isa_pkg::*, lc_map_pkg::*; (
    input  logic     sysclk,
    input  logic     sysrst,
    input  logic     core_run,
    input  logic     result_go,
    input  logic     wb_en,
    input  reg_idx_t wb_idx,
    input  word_t    wb_val,
    input  logic     pc_load,
    input  word_t    pc_target,
    input  logic     halt_req,
    input  reg_idx_t ra_idx,
    input  reg_idx_t rb_idx,
    output word_t    ra_val,
    output word_t    rb_val,
    output word_t    pc,
    output logic     halted
);
    word_t regs [16];

    // two combinational read ports for decode
    assign ra_val = regs[ra_idx];
    assign rb_val = regs[rb_idx];

    // whole core state restarts while the loader holds the core
    always_ff @(posedge sysclk) begin
        if (!sysrst || !core_run) begin
            regs   <= '{default: '0};
            pc     <= '0;
            halted <= 1'b0;
        end else if (result_go) begin
            if (wb_en) begin
                regs[wb_idx] <= wb_val;
            end
            if (pc_load) begin
                pc <= pc_target;
            end else begin
                pc <= pc + 1'b1;
            end
            if (halt_req) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// ==== cpu/cpu_execute.sv ====
`timescale 1ns/10ps

module cpu_execute import lc_isa_pkg::*, lc_map_pkg::*; (
    input  logic       sysclk,
    input  logic       sysrst,
    input  logic       exec_go,
    input  opcode_t    op,
    input  reg_idx_t   rd_idx,
    input  logic [7:0] imm8,
    input  word_t      opa,
    input  word_t      opb,
    output word_t      dmem_addr,
    output logic       dmem_we,
    output word_t      dmem_wdata,
    input  word_t      dmem_rdata,
    output logic       result_go,
    output logic       wb_en,
    output reg_idx_t   wb_idx,
    output word_t      wb_val,
    output logic       pc_load,
    output word_t      pc_target,
    output logic       halt_req
);
    word_t alu_res;
    logic  writes_rd;
    logic  taken;

    always_comb begin
        case (op)
            ADD:     alu_res = opa + opb;
            SUB:     alu_res = opa - opb;
            AND:     alu_res = opa & opb;
            OR:      alu_res = opa | opb;
            XOR:     alu_res = opa ^ opb;
            LI:      alu_res = {8'h00, imm8};
            // upper byte replaced, lower byte of rd kept
            LUI:     alu_res = {imm8, opb[7:0]};
            LW:      alu_res = dmem_rdata;
            default: alu_res = '0;
        endcase
    end

    assign writes_rd = op inside {ADD, SUB, AND, OR, XOR, LI, LUI, LW};
    assign taken     = (op == JMP) || (op == BNZ && opb != '0);

    // single memory access, address from ra, store data from rd
    assign dmem_addr  = opa;
    assign dmem_wdata = opb;
    assign dmem_we    = exec_go && op == SW;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            result_go <= 1'b0;
            wb_en     <= 1'b0;
            pc_load   <= 1'b0;
            halt_req  <= 1'b0;
        end else begin
            result_go <= exec_go;
            wb_en     <= exec_go && writes_rd;
            pc_load   <= exec_go && taken;
            halt_req  <= exec_go && op == HALT;
        end
    end

    always_ff @(posedge sysclk) begin
        if (exec_go) begin
            wb_idx    <= rd_idx;
            wb_val    <= alu_res;
            pc_target <= {8'h00, imm8};
        end
    end

endmodule

// ==== cpu/cpu_decode.sv ====
`timescale 1ns/10ps

module cpu_decode import lc_isa_pkg::*, lc_map_pkg::*; (
    input  logic       sysclk,
    input  logic       sysrst,
    input  logic       core_run,
    input  instr_u     instr,
    input  logic       result_go,
    input  logic       halted,
    output reg_idx_t   ra_idx,
    output reg_idx_t   rb_idx,
    input  word_t      ra_val,
    input  word_t      rb_val,
    output logic       exec_go,
    output opcode_t    op,
    output reg_idx_t   rd_idx,
    output logic [7:0] imm8,
    output word_t      opa,
    output word_t      opb
);
    // one-hot sequencer
    localparam logic [2:0] S_DECODE   = 3'b001;
    localparam logic [2:0] S_WAIT_EX  = 3'b010;
    localparam logic [2:0] S_WAIT_RES = 3'b100;

    logic [2:0] state;
    opcode_t    cur_op;
    reg_idx_t   cur_rd;
    logic       use_imm;
    logic       rd_read;

    assign cur_op  = instr.r_form.opcode;
    assign use_imm = cur_op inside {LI, LUI, JMP, BNZ};
    // rd sits in the same bits in both formats
    assign cur_rd  = instr.r_form.rd;

    // SW, BNZ and LUI need rd's current value on the second port
    assign rd_read = cur_op inside {SW, BNZ, LUI};
    assign ra_idx  = instr.r_form.ra;
    assign rb_idx  = rd_read ? cur_rd : instr.r_form.rb;

    always_ff @(posedge sysclk) begin
        if (!sysrst || !core_run) begin
            state   <= S_DECODE;
            exec_go <= 1'b0;
        end else begin
            exec_go <= 1'b0;
            case (1'b1)
                state[0]: if (!halted) begin
                    state   <= S_WAIT_EX;
                    exec_go <= 1'b1;
                end
                state[1]: state <= S_WAIT_RES;
                state[2]: if (result_go) state <= S_DECODE;
                default:  state <= S_DECODE;
            endcase
        end
    end

    // operand latch
    always_ff @(posedge sysclk) begin
        if (state[0]) begin
            op     <= cur_op;
            rd_idx <= cur_rd;
            imm8   <= use_imm ? instr.i_form.imm8 : 8'h00;
            opa    <= ra_val;
            opb    <= rb_val;
        end
    end

endmodule

// ==== hw/mem_map.sv ====
`timescale 1ns/10ps

module mem_map import lc_isa_pkg::*, lc_map_pkg::*; #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                          sysclk,
    input  logic                          sysrst,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_waddr,
    input  word_t                         imem_wdata,
    input  word_t                         pc,
    output instr_u                        imem_rdata,
    input  word_t                         dmem_addr,
    input  logic                          dmem_we,
    input  word_t                         dmem_wdata,
    output word_t                         dmem_rdata,
    output logic [LED_WIDTH-1:0]          led,
    output logic [7:0]                    tx_byte,
    output logic                          tx_valid
);
    localparam int IAW = $clog2(IMEM_WORDS);
    localparam int DAW = $clog2(DMEM_WORDS);

    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];

    logic [IAW-1:0] pc_idx;
    logic [DAW-1:0] d_idx;
    logic           is_ram;
    logic           is_led;
    logic           is_tx;
    logic [7:0]     tx_hold;

    assign pc_idx = IAW'(pc % IMEM_WORDS);
    assign d_idx  = DAW'(dmem_addr % DMEM_WORDS);

    // address decode
    assign is_ram = dmem_addr < ADDR_LED;
    assign is_led = dmem_addr == ADDR_LED;
    assign is_tx  = dmem_addr == ADDR_TX;

    // instruction fetch, combinational at pc
    assign imem_rdata = imem[pc_idx];

    always_ff @(posedge sysclk) begin
        if (imem_we) begin
            imem[imem_waddr] <= imem_wdata;
        end
        if (dmem_we && is_ram) begin
            dmem[d_idx] <= dmem_wdata;
        end
    end

    // data read mux; unmapped addresses and the tx port read as zero
    always_comb begin
        if (is_ram) begin
            dmem_rdata = dmem[d_idx];
        end else if (is_led) begin
            dmem_rdata = word_t'(led);
        end else begin
            dmem_rdata = '0;
        end
    end

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            led <= '0;
        end else if (dmem_we && is_led) begin
            led <= dmem_wdata[LED_WIDTH-1:0];
        end
    end

    // transmit strobe goes out with the store itself
    assign tx_valid = dmem_we & is_tx;

    always_ff @(posedge sysclk) begin
        if (tx_valid) begin
            tx_hold <= dmem_wdata[7:0];
        end
    end

    // last sent byte stays on the port between strobes
    assign tx_byte = tx_valid ? dmem_wdata[7:0] : tx_hold;

endmodule

// ==== hw/prog_loader.sv ====
`timescale 1ns/10ps

module prog_loader import lc_map_pkg::*; #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          sysclk,
    input  logic                          sysrst,
    input  logic                          load_en,
    input  logic [7:0]                    rx_byte,
    input  logic                          rx_valid,
    output logic                          imem_we,
    output logic [$clog2(IMEM_WORDS)-1:0] imem_waddr,
    output word_t                         imem_wdata,
    output logic                          core_run
);
    localparam int AW = $clog2(IMEM_WORDS);

    logic       load_d;
    logic       load_rise;
    logic       phase;
    logic [7:0] hi_byte;

    // restart the word address on each new load
    assign load_rise = load_en & ~load_d;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            load_d     <= 1'b0;
            core_run   <= 1'b0;
            imem_we    <= 1'b0;
            imem_waddr <= '0;
            phase      <= 1'b0;
        end else begin
            load_d   <= load_en;
            core_run <= ~load_en;
            imem_we  <= 1'b0;
            if (load_rise) begin
                imem_waddr <= '0;
                phase      <= 1'b0;
            end else if (imem_we) begin
                imem_waddr <= (imem_waddr == AW'(IMEM_WORDS - 1)) ? '0 : imem_waddr + 1'b1;
            end
            // a byte on the edge cycle starts a fresh pair
            if (load_en && rx_valid) begin
                if (phase && !load_rise) begin
                    imem_we <= 1'b1;
                    phase   <= 1'b0;
                end else begin
                    phase <= 1'b1;
                end
            end
        end
    end

    // high byte arrives first
    always_ff @(posedge sysclk) begin
        if (load_en && rx_valid) begin
            if (phase && !load_rise) begin
                imem_wdata <= {hi_byte, rx_byte};
            end else begin
                hi_byte <= rx_byte;
            end
        end
    end

endmodule

// ==== common/lc_isa_pkg.sv ====
package lc_isa_pkg;

    // instruction opcodes, upper nibble of every instruction word
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        LI   = 4'h5,
        LUI  = 4'h6,
        LW   = 4'h7,
        SW   = 4'h8,
        JMP  = 4'h9,
        BNZ  = 4'hA,
        HALT = 4'hB
    } opcode_t;

    // 16 general purpose registers
    typedef logic [3:0] reg_idx_t;

    // three register operands
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t ra;
        reg_idx_t rb;
    } r_form_t;

    // destination plus 8-bit immediate
    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;
        logic [7:0] imm8;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } instr_u;

endpackage

// ==== common/lc_map_pkg.sv ====
package lc_map_pkg;

    // data and address word
    typedef logic [15:0] word_t;

    // LED register width
    localparam int LED_WIDTH = 10;

    // memory-mapped peripherals at the top of the data space
    localparam word_t ADDR_LED = 16'hFF00;
    localparam word_t ADDR_TX  = 16'hFF01;

    // everything below ADDR_LED is data RAM, wrapped at its depth

endpackage
